/* include/dbg_defines.svh */
// ==========================================================================
// sizing macros for the debug bridge: frame and word widths, capture depth
// and the idle pipeline select code
// ==========================================================================
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// width of every command and response frame
`define DBG_FRAME_W 32

// width of one word captured from the pipeline
`define DBG_REG_W 32

// number of pipeline words a single capture can hold
`define DBG_BUF_WORDS 3

// select code that matches no source on the pipeline side
`define DBG_SEL_NONE 6'b111111

`endif

/* hw/dbg_pkg.sv */
// ==========================================================================
// debug bridge types: command and request codes, command frame layout,
// pipeline control bundle, response kinds and response frame codes
// ==========================================================================
`default_nettype none

`include "dbg_defines.svh"

package dbg_pkg;

   // command codes carried in the top six bits of a frame
   typedef enum logic [5:0] {
      CMD_START         = 6'd1,
      CMD_RESET         = 6'd2,
      CMD_REQ_DATA      = 6'd3,
      CMD_LOAD_LSB      = 6'd4,
      CMD_LOAD_MSB      = 6'd5,
      CMD_MODE_GET      = 6'd8,
      CMD_MODE_SET_CONT = 6'd9,
      CMD_MODE_SET_STEP = 6'd10,
      CMD_STEP          = 6'd32,
      CMD_GOT_DATA      = 6'd36,
      CMD_GIB_DATA      = 6'd37
   } cmd_code_e;

   // request types, low bit picks control over data for the latches
   typedef enum logic [8:0] {
      REQ_MEM_DATA         = 9'b000_0000_01,
      REQ_MEM_INSTR        = 9'b000_0000_10,
      REQ_REG              = 9'b000_0001_00,
      REQ_REG_PC           = 9'b000_0001_01,
      REQ_LATCH_FETCH_DATA = 9'b000_0010_00,
      REQ_LATCH_FETCH_CTRL = 9'b000_0010_01,
      REQ_LATCH_DECO_DATA  = 9'b000_0100_00,
      REQ_LATCH_DECO_CTRL  = 9'b000_0100_01,
      REQ_LATCH_EXEC_DATA  = 9'b000_1000_00,
      REQ_LATCH_EXEC_CTRL  = 9'b000_1000_01,
      REQ_LATCH_MEM_DATA   = 9'b001_0000_00,
      REQ_LATCH_MEM_CTRL   = 9'b001_0000_01
   } req_type_e;

   // frame written by the control processor
   typedef struct packed {
      cmd_code_e   code;
      logic        strobe;
      req_type_e   req_type;
      logic [15:0] data;
   } cmd_frame_t;

   // control bundle toward the pipeline under test
   typedef struct packed {
      logic                  reset;
      logic                  valid;
      logic [3:0]            instr_we;
      logic [8:0]            instr_addr;
      logic [`DBG_REG_W-1:0] instr_data;
      logic [15:0]           mem_addr;
      logic [5:0]            request_select;
   } mips_ctrl_t;

   typedef enum logic [2:0] {
      RESP_NONE,
      RESP_OK,
      RESP_NOK,
      RESP_DATA,
      RESP_MODE,
      RESP_EOP
   } resp_sel_e;

   // response frames, code on top and zeros below
   localparam logic [`DBG_FRAME_W-1:0] FRAME_OK        = {6'd3, {(`DBG_FRAME_W-6){1'b0}}};
   localparam logic [`DBG_FRAME_W-1:0] FRAME_NOK       = {6'd2, {(`DBG_FRAME_W-6){1'b0}}};
   localparam logic [`DBG_FRAME_W-1:0] FRAME_EOP       = {6'd4, {(`DBG_FRAME_W-6){1'b0}}};
   localparam logic [`DBG_FRAME_W-1:0] FRAME_MODE_CONT = {6'd9, {(`DBG_FRAME_W-6){1'b0}}};
   localparam logic [`DBG_FRAME_W-1:0] FRAME_MODE_STEP = {6'd10, {(`DBG_FRAME_W-6){1'b0}}};

endpackage

`default_nettype wire

/* hw/dbg_request_decoder.sv */
// ==========================================================================
// request type to pipeline select code translation
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_request_decoder (
   input  wire dbg_pkg::req_type_e i_req_type,
   input  wire [4:0]               i_reg_num,
   output logic [5:0]              o_select
);

   import dbg_pkg::*;

   // latch codes run 36..43, data before control per stage
   always_comb begin
      case (i_req_type)
         REQ_MEM_DATA:         o_select = 6'd32;
         REQ_MEM_INSTR:        o_select = 6'd33;
         REQ_REG:              o_select = {1'b0, i_reg_num};
         REQ_REG_PC:           o_select = 6'd34;
         REQ_LATCH_FETCH_DATA: o_select = 6'd36;
         REQ_LATCH_FETCH_CTRL: o_select = 6'd37;
         REQ_LATCH_DECO_DATA:  o_select = 6'd38;
         REQ_LATCH_DECO_CTRL:  o_select = 6'd39;
         REQ_LATCH_EXEC_DATA:  o_select = 6'd40;
         REQ_LATCH_EXEC_CTRL:  o_select = 6'd41;
         REQ_LATCH_MEM_DATA:   o_select = 6'd42;
         REQ_LATCH_MEM_CTRL:   o_select = 6'd43;
         default:              o_select = `DBG_SEL_NONE;
      endcase
   end

endmodule

`default_nettype wire

/* hw/dbg_cmd_fsm.sv */
// ==========================================================================
// command strobe edge detector, run and mode state, and decode of the
// command code into pipeline control and response selection
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_cmd_fsm (
   input  wire                        i_clock,
   input  wire                        i_reset,
   input  wire dbg_pkg::cmd_frame_t   i_frame,
   input  wire [5:0]                  i_select_code,
   output dbg_pkg::mips_ctrl_t        o_mips_ctrl,
   output logic                       o_fire,
   output logic                       o_start_capture,
   output logic                       o_read_next,
   output dbg_pkg::resp_sel_e         o_resp_sel,
   output logic                       o_step_mode
);

   import dbg_pkg::*;

   logic strobe_q;
   logic running;
   logic step_mode;

   // previous strobe sample for the rising edge
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         strobe_q <= 1'b0;
      end else begin
         strobe_q <= i_frame.strobe;
      end
   end

   assign o_fire      = i_frame.strobe & ~strobe_q;
   assign o_step_mode = step_mode;

   // run flag and execution mode, updated on the edge closing the fire cycle
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         running   <= 1'b0;
         step_mode <= 1'b0;
      end else if (o_fire) begin
         case (i_frame.code)
            CMD_START: begin
               running <= 1'b1;
            end
            CMD_RESET: begin
               running <= 1'b0;
            end
            CMD_MODE_SET_CONT: begin
               step_mode <= 1'b0;
            end
            CMD_MODE_SET_STEP: begin
               step_mode <= 1'b1;
            end
            default: begin
            end
         endcase
      end
   end

   always_comb begin
      o_mips_ctrl.reset          = 1'b0;
      o_mips_ctrl.instr_we       = 4'b0000;
      o_mips_ctrl.instr_addr     = i_frame.req_type;
      o_mips_ctrl.mem_addr       = i_frame.data;
      o_mips_ctrl.request_select = `DBG_SEL_NONE;
      // msb load places the data field in the upper half
      if (i_frame.code == CMD_LOAD_MSB) begin
         o_mips_ctrl.instr_data = {i_frame.data, 16'h0000};
      end else begin
         o_mips_ctrl.instr_data = {16'h0000, i_frame.data};
      end
      // continuous mode follows the run flag, step mode only pulses
      o_mips_ctrl.valid = step_mode ? 1'b0 : running;
      o_start_capture   = 1'b0;
      o_read_next       = 1'b0;
      o_resp_sel        = RESP_NONE;

      if (o_fire) begin
         // eop or nok unless the command asks for something else
         o_resp_sel = RESP_EOP;
         case (i_frame.code)
            CMD_START, CMD_STEP: begin
               if (step_mode) begin
                  o_mips_ctrl.valid = 1'b1;
               end
            end
            CMD_RESET: begin
               o_mips_ctrl.reset = 1'b1;
               o_mips_ctrl.valid = 1'b0;
            end
            CMD_LOAD_LSB: begin
               o_mips_ctrl.instr_we = 4'b0011;
            end
            CMD_LOAD_MSB: begin
               o_mips_ctrl.instr_we = 4'b1100;
            end
            CMD_REQ_DATA: begin
               o_mips_ctrl.request_select = i_select_code;
               o_start_capture            = 1'b1;
            end
            CMD_MODE_GET: begin
               o_resp_sel = RESP_MODE;
            end
            CMD_GOT_DATA: begin
               o_resp_sel = RESP_OK;
            end
            CMD_GIB_DATA: begin
               o_resp_sel  = RESP_DATA;
               o_read_next = 1'b1;
            end
            default: begin
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/dbg_capture_timer.sv */
// ==========================================================================
// capture pacing: enable flag, saturating fill count and readout pointer
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_capture_timer (
   input  wire        i_clock,
   input  wire        i_reset,
   input  wire        i_start_capture,
   input  wire        i_eod,
   input  wire        i_read_next,
   output logic       o_capture_en,
   output logic [1:0] o_fill,
   output logic [1:0] o_read_ptr
);

   logic capture_run;

   // no store once eod shows up or the buffer is full
   assign o_capture_en = capture_run & ~i_eod & (o_fill != 2'(`DBG_BUF_WORDS));

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         capture_run <= 1'b0;
      end else if (i_start_capture) begin
         capture_run <= 1'b1;
      end else if (i_eod) begin
         capture_run <= 1'b0;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset || i_start_capture) begin
         o_fill <= 2'd0;
      end else if (o_capture_en) begin
         o_fill <= o_fill + 2'd1;
      end
   end

   // pointer stops at the fill count, so extra reads keep answering nok
   always_ff @(posedge i_clock) begin
      if (i_reset || i_start_capture) begin
         o_read_ptr <= 2'd0;
      end else if (i_read_next && (o_read_ptr < o_fill)) begin
         o_read_ptr <= o_read_ptr + 2'd1;
      end
   end

endmodule

`default_nettype wire

/* hw/dbg_capture_buffer.sv */
// ==========================================================================
// store for captured pipeline words, response frame selection and the
// registered response toward the control processor
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_capture_buffer (
   input  wire                       i_clock,
   input  wire                       i_reset,
   input  wire                       i_capture_en,
   input  wire [1:0]                 i_fill,
   input  wire [1:0]                 i_read_ptr,
   input  wire [`DBG_REG_W-1:0]      i_word,
   input  wire dbg_pkg::resp_sel_e   i_resp_sel,
   input  wire                       i_fire,
   input  wire                       i_step_mode,
   input  wire                       i_eop,
   output logic [`DBG_FRAME_W-1:0]   o_frame
);

   import dbg_pkg::*;

   logic [`DBG_REG_W-1:0]   words [`DBG_BUF_WORDS];
   logic                    have_word;
   logic [`DBG_FRAME_W-1:0] next_frame;

   // slot index is the fill count at the time of the store
   always_ff @(posedge i_clock) begin
      if (i_capture_en) begin
         words[i_fill] <= i_word;
      end
   end

   assign have_word = i_read_ptr < i_fill;

   always_comb begin
      case (i_resp_sel)
         RESP_OK: begin
            next_frame = have_word ? FRAME_OK : FRAME_NOK;
         end
         RESP_DATA: begin
            next_frame = have_word ? words[i_read_ptr] : FRAME_NOK;
         end
         RESP_MODE: begin
            next_frame = i_step_mode ? FRAME_MODE_STEP : FRAME_MODE_CONT;
         end
         RESP_EOP: begin
            next_frame = i_eop ? FRAME_EOP : FRAME_NOK;
         end
         default: begin
            next_frame = FRAME_NOK;
         end
      endcase
   end

   // response holds until the next command
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_frame <= '0;
      end else if (i_fire) begin
         o_frame <= next_frame;
      end
   end

endmodule

`default_nettype wire

/* hw/dbg_bridge_top.sv */
// ==========================================================================
// debug bridge top: command FSM, capture timer, capture buffer and
// request decoder between the control processor and the pipeline
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_bridge_top (
   input  wire                       i_clock,
   input  wire                       i_reset,
   input  wire dbg_pkg::cmd_frame_t  i_frame_from_ctrl,
   input  wire [`DBG_FRAME_W-1:0]    i_frame_from_mips,
   input  wire                       i_eod,
   input  wire                       i_eop,
   output dbg_pkg::mips_ctrl_t       o_mips_ctrl,
   output logic [`DBG_FRAME_W-1:0]   o_frame_to_ctrl
);

   import dbg_pkg::*;

   logic       fire;
   logic       start_capture;
   logic       read_next;
   logic       step_mode;
   logic       capture_en;
   logic [1:0] fill;
   logic [1:0] read_ptr;
   logic [5:0] select_code;
   resp_sel_e  resp_sel;

   // register number sits in the low bits of the data field
   dbg_request_decoder u_decoder (
      .i_req_type (i_frame_from_ctrl.req_type),
      .i_reg_num  (i_frame_from_ctrl.data[4:0]),
      .o_select   (select_code)
   );

   dbg_cmd_fsm u_cmd_fsm (
      .i_clock         (i_clock),
      .i_reset         (i_reset),
      .i_frame         (i_frame_from_ctrl),
      .i_select_code   (select_code),
      .o_mips_ctrl     (o_mips_ctrl),
      .o_fire          (fire),
      .o_start_capture (start_capture),
      .o_read_next     (read_next),
      .o_resp_sel      (resp_sel),
      .o_step_mode     (step_mode)
   );

   dbg_capture_timer u_timer (
      .i_clock         (i_clock),
      .i_reset         (i_reset),
      .i_start_capture (start_capture),
      .i_eod           (i_eod),
      .i_read_next     (read_next),
      .o_capture_en    (capture_en),
      .o_fill          (fill),
      .o_read_ptr      (read_ptr)
   );

   dbg_capture_buffer u_buffer (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_capture_en(capture_en),
      .i_fill      (fill),
      .i_read_ptr  (read_ptr),
      .i_word      (i_frame_from_mips),
      .i_resp_sel  (resp_sel),
      .i_fire      (fire),
      .i_step_mode (step_mode),
      .i_eop       (i_eop),
      .o_frame     (o_frame_to_ctrl)
   );

endmodule

`default_nettype wire

/* verif/dbg_bridge_assert.sv */
// ==========================================================================
// concurrent assertions on the debug bridge top, attached by bind
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_bridge_assert (
   input wire                      i_clock,
   input wire                      i_reset,
   input wire dbg_pkg::cmd_frame_t i_frame_from_ctrl,
   input wire dbg_pkg::mips_ctrl_t i_mips_ctrl,
   input wire [`DBG_FRAME_W-1:0]   i_frame_to_ctrl
);

   // only whole half-word write patterns reach instruction memory
   assert property (@(posedge i_clock) disable iff (i_reset)
      i_mips_ctrl.instr_we inside {4'b0000, 4'b0011, 4'b1100})
      else $error("instr_we shows an illegal byte pattern");

   // loads and resets never select a data source
   assert property (@(posedge i_clock) disable iff (i_reset)
      (i_mips_ctrl.instr_we != 4'b0000 || i_mips_ctrl.reset) |->
         i_mips_ctrl.request_select == `DBG_SEL_NONE)
      else $error("request_select active during a load or reset");

   // response moves only on the edge that closes a fire cycle
   assert property (@(posedge i_clock) disable iff (i_reset)
      (!$past(i_reset) && $changed(i_frame_to_ctrl)) |->
         ($past(i_frame_from_ctrl.strobe) && !$past(i_frame_from_ctrl.strobe, 2)))
      else $error("response frame changed without a strobe edge");

endmodule

bind dbg_bridge_top dbg_bridge_assert u_bridge_assert (
   .i_clock           (i_clock),
   .i_reset           (i_reset),
   .i_frame_from_ctrl (i_frame_from_ctrl),
   .i_mips_ctrl       (o_mips_ctrl),
   .i_frame_to_ctrl   (o_frame_to_ctrl)
);

`default_nettype wire

/* verif/dbg_bridge_tb.sv */
// ==========================================================================
// directed testbench for the debug bridge: clock, reset, watchdog,
// pipeline word model and one task per checked behavior
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_bridge_tb;

   import dbg_pkg::*;

   localparam int CLOCK_PERIOD = 8;
   localparam int NUM_TESTS    = 6;

   logic                    clock;
   logic                    reset;
   cmd_frame_t              frame_from_ctrl;
   logic [`DBG_FRAME_W-1:0] frame_from_mips;
   logic                    eod;
   logic                    eop;
   mips_ctrl_t              mips_ctrl;
   logic [`DBG_FRAME_W-1:0] frame_to_ctrl;

   dbg_bridge_top UUT (
      .i_clock           (clock),
      .i_reset           (reset),
      .i_frame_from_ctrl (frame_from_ctrl),
      .i_frame_from_mips (frame_from_mips),
      .i_eod             (eod),
      .i_eop             (eop),
      .o_mips_ctrl       (mips_ctrl),
      .o_frame_to_ctrl   (frame_to_ctrl)
   );

   initial begin
      clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) clock = ~clock;
   end

   initial begin
      #(NUM_TESTS * 200 * CLOCK_PERIOD);
      $display("watchdog expired before the tests completed");
      $display("TESTS FAILED");
      $fatal(1, "run stopped by the watchdog");
   end

   // response code in the top six bits, zeros below
   function automatic logic [31:0] code_frame(input logic [5:0] code);
      return {code, 26'd0};
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected) begin
         $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("TESTS FAILED");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   // control seen mid fire cycle, response seen one cycle later
   task automatic run_cmd(input cmd_code_e code, input req_type_e rt, input logic [15:0] data,
                          output mips_ctrl_t fire_ctrl, output logic [31:0] resp);
      @(posedge clock);
      frame_from_ctrl <= {code, 1'b1, rt, data};
      @(negedge clock);
      fire_ctrl = mips_ctrl;
      @(posedge clock);
      frame_from_ctrl.strobe <= 1'b0;
      @(negedge clock);
      resp = frame_to_ctrl;
   endtask

   task automatic test_after_reset();
      check(32'(mips_ctrl.reset), 0, "reset after reset");
      check(32'(mips_ctrl.valid), 0, "valid after reset");
      check(32'(mips_ctrl.instr_we), 0, "instr_we after reset");
      check(32'(mips_ctrl.request_select), 32'h3f, "select after reset");
      check(frame_to_ctrl, 0, "response after reset");
   endtask

   task automatic test_loads();
      mips_ctrl_t  ctrl;
      logic [31:0] resp;
      run_cmd(CMD_LOAD_LSB, req_type_e'(9'h0a5), 16'hbeef, ctrl, resp);
      check(32'(ctrl.instr_we), 32'b0011, "lsb write enable");
      check(ctrl.instr_data, 32'h0000_beef, "lsb data");
      check(32'(ctrl.instr_addr), 32'h0a5, "lsb address");
      check(32'(ctrl.request_select), 32'h3f, "select during lsb load");
      run_cmd(CMD_LOAD_MSB, req_type_e'(9'h15a), 16'hcafe, ctrl, resp);
      check(32'(ctrl.instr_we), 32'b1100, "msb write enable");
      check(ctrl.instr_data, 32'hcafe_0000, "msb data");
      check(32'(ctrl.instr_addr), 32'h15a, "msb address");
      check(32'(mips_ctrl.instr_we), 0, "write enable after load");
   endtask

   task automatic test_modes();
      mips_ctrl_t  ctrl;
      logic [31:0] resp;
      run_cmd(CMD_MODE_SET_STEP, REQ_MEM_DATA, 16'h0, ctrl, resp);
      run_cmd(CMD_MODE_GET, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, code_frame(6'd10), "mode after set step");
      check(32'(ctrl.valid), 0, "valid on mode get in step mode");
      run_cmd(CMD_STEP, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(32'(ctrl.valid), 1, "valid on step");
      check(32'(mips_ctrl.valid), 0, "valid after step");
      run_cmd(CMD_MODE_SET_CONT, REQ_MEM_DATA, 16'h0, ctrl, resp);
      run_cmd(CMD_MODE_GET, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, code_frame(6'd9), "mode after set cont");
      run_cmd(CMD_START, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(32'(mips_ctrl.valid), 1, "valid after start");
      run_cmd(CMD_MODE_GET, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(32'(mips_ctrl.valid), 1, "valid held while running");
      run_cmd(CMD_RESET, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(32'(ctrl.reset), 1, "reset pulse");
      check(32'(ctrl.valid), 0, "valid during reset");
      check(32'(mips_ctrl.reset), 0, "reset after pulse");
      check(32'(mips_ctrl.valid), 0, "valid after reset command");
   endtask

   task automatic test_requests();
      req_type_e   types [12] = '{REQ_MEM_DATA, REQ_MEM_INSTR, REQ_REG, REQ_REG_PC,
                                  REQ_LATCH_FETCH_DATA, REQ_LATCH_FETCH_CTRL,
                                  REQ_LATCH_DECO_DATA, REQ_LATCH_DECO_CTRL,
                                  REQ_LATCH_EXEC_DATA, REQ_LATCH_EXEC_CTRL,
                                  REQ_LATCH_MEM_DATA, REQ_LATCH_MEM_CTRL};
      int          codes [12] = '{32, 33, 13, 34, 36, 37, 38, 39, 40, 41, 42, 43};
      mips_ctrl_t  ctrl;
      logic [31:0] resp;
      for (int i = 0; i < 12; i++) begin
         run_cmd(CMD_REQ_DATA, types[i], 16'd13, ctrl, resp);
         check(32'(ctrl.request_select), codes[i], "request select code");
      end
      run_cmd(CMD_REQ_DATA, REQ_REG, 16'd31, ctrl, resp);
      check(32'(ctrl.request_select), 31, "register number select");
      // memory address follows the data field of the frame
      run_cmd(CMD_REQ_DATA, REQ_MEM_DATA, 16'h1234, ctrl, resp);
      check(32'(ctrl.mem_addr), 32'h1234, "memory address");
   endtask

   task automatic test_capture();
      mips_ctrl_t  ctrl;
      logic [31:0] resp;
      logic [31:0] word0;
      logic [31:0] word1;
      word0 = $urandom;
      word1 = $urandom;
      // pipeline model holds the first word before the request fires
      @(posedge clock);
      frame_from_mips <= word0;
      run_cmd(CMD_REQ_DATA, REQ_REG, 16'd4, ctrl, resp);
      @(posedge clock);
      frame_from_mips <= word1;
      @(posedge clock);
      eod <= 1'b1;
      @(posedge clock);
      eod             <= 1'b0;
      frame_from_mips <= $urandom;
      run_cmd(CMD_GOT_DATA, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, code_frame(6'd3), "got data with words");
      run_cmd(CMD_GIB_DATA, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, word0, "first captured word");
      run_cmd(CMD_GIB_DATA, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, word1, "second captured word");
      run_cmd(CMD_GIB_DATA, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, code_frame(6'd2), "read past the capture");
      run_cmd(CMD_GOT_DATA, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, code_frame(6'd2), "got data when drained");
   endtask

   task automatic test_end_of_program();
      mips_ctrl_t  ctrl;
      logic [31:0] resp;
      @(posedge clock);
      eop <= 1'b1;
      run_cmd(CMD_START, REQ_MEM_DATA, 16'h0, ctrl, resp);
      check(resp, code_frame(6'd4), "end of program marker");
      @(posedge clock);
      eop <= 1'b0;
   endtask

   initial begin
      void'($urandom(93527));
      reset           = 1'b1;
      frame_from_ctrl = '0;
      frame_from_mips = '0;
      eod             = 1'b0;
      eop             = 1'b0;
      repeat (2) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      test_after_reset();
      test_loads();
      test_modes();
      test_requests();
      test_capture();
      test_end_of_program();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
hw/dbg_pkg.sv
hw/dbg_request_decoder.sv
hw/dbg_cmd_fsm.sv
hw/dbg_capture_timer.sv
hw/dbg_capture_buffer.sv
hw/dbg_bridge_top.sv
verif/dbg_bridge_assert.sv
verif/dbg_bridge_tb.sv

/* Bender.yml */
package:
  name: dbg_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/dbg_pkg.sv
      - hw/dbg_request_decoder.sv
      - hw/dbg_cmd_fsm.sv
      - hw/dbg_capture_timer.sv
      - hw/dbg_capture_buffer.sv
      - hw/dbg_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/dbg_bridge_assert.sv
      - verif/dbg_bridge_tb.sv
